//--- verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

  localparam int data_w = 16;  // Datapath and instruction width
  localparam int op_w   = 5;   // Opcode width

  // Field positions in the instruction word
  localparam int op_msb     = 15;
  localparam int op_lsb     = 11;
  localparam int fn_msb     = 1;   // Function code for register forms
  localparam int fn_lsb     = 0;
  localparam int imm5_msb   = 4;
  localparam int imm8_msb   = 7;
  localparam int disp11_msb = 10;

  // Immediate arithmetic and logic
  localparam logic [op_w-1:0] op_addi  = 5'b01000;
  localparam logic [op_w-1:0] op_subi  = 5'b01001;  // imm - rs
  localparam logic [op_w-1:0] op_xori  = 5'b01010;
  localparam logic [op_w-1:0] op_andni = 5'b01011;

  // Immediate shifts and rotates
  localparam logic [op_w-1:0] op_roli = 5'b10100;
  localparam logic [op_w-1:0] op_slli = 5'b10101;
  localparam logic [op_w-1:0] op_rori = 5'b10110;
  localparam logic [op_w-1:0] op_srli = 5'b10111;

  // Memory, address is rs + imm5
  localparam logic [op_w-1:0] op_st  = 5'b10000;
  localparam logic [op_w-1:0] op_ld  = 5'b10001;
  localparam logic [op_w-1:0] op_stu = 5'b10011;

  localparam logic [op_w-1:0] op_btr     = 5'b11001;
  localparam logic [op_w-1:0] op_alu_r   = 5'b11011;  // add/sub/xor/andn by function
  localparam logic [op_w-1:0] op_shift_r = 5'b11010;  // rol/sll/ror/srl by function

  // Set ops, low two opcode bits pick the condition
  localparam logic [op_w-1:0] op_seq = 5'b11100;
  localparam logic [op_w-1:0] op_slt = 5'b11101;
  localparam logic [op_w-1:0] op_sle = 5'b11110;
  localparam logic [op_w-1:0] op_sco = 5'b11111;

  localparam logic [op_w-1:0] op_beqz = 5'b01100;
  localparam logic [op_w-1:0] op_bnez = 5'b01101;
  localparam logic [op_w-1:0] op_bltz = 5'b01110;
  localparam logic [op_w-1:0] op_bgez = 5'b01111;

  localparam logic [op_w-1:0] op_lbi  = 5'b11000;
  localparam logic [op_w-1:0] op_slbi = 5'b10010;

  localparam logic [op_w-1:0] op_j    = 5'b00100;
  localparam logic [op_w-1:0] op_jr   = 5'b00101;
  localparam logic [op_w-1:0] op_jal  = 5'b00110;
  localparam logic [op_w-1:0] op_jalr = 5'b00111;

  localparam logic [op_w-1:0] op_nop = 5'b00001;

endpackage

`default_nettype wire

//--- verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

  // Low two bits match the register-form function code
  typedef enum logic [2:0] {
    alu_add  = 3'd0,
    alu_sub  = 3'd1,
    alu_xor  = 3'd2,
    alu_andn = 3'd3,
    alu_rol  = 3'd4,
    alu_sll  = 3'd5,
    alu_ror  = 3'd6,
    alu_srl  = 3'd7
  } alu_op_t;

  typedef enum logic [1:0] {
    b_read2    = 2'd0,  // A op read2data
    b_imm      = 2'd1,  // A op imm
    b_imm_swap = 2'd2   // imm op read1data, used by subi
  } b_sel_t;

  typedef enum logic [2:0] {
    res_alu      = 3'd0,
    res_pass_b   = 3'd1,
    res_set_cond = 3'd2,
    res_btr      = 3'd3,
    res_slbi     = 3'd4
  } res_sel_t;

  // Same order as the low bits of the set opcodes
  typedef enum logic [1:0] {
    cond_eq = 2'd0,
    cond_lt = 2'd1,
    cond_le = 2'd2,
    cond_co = 2'd3
  } set_cond_t;

  typedef enum logic {
    jb_pc    = 1'b0,  // pc + 2 + imm
    jb_read1 = 1'b1   // read1data + imm
  } jump_base_t;

  // Decoded controls plus operands, first stage payload
  typedef struct packed {
    alu_op_t                      alu_op;
    b_sel_t                       b_sel;
    res_sel_t                     res_sel;
    set_cond_t                    set_cond;
    jump_base_t                   jump_base;
    logic [isa_pkg::data_w-1:0]   imm;
    logic                         illegal;
    logic [isa_pkg::data_w-1:0]   read1data;
    logic [isa_pkg::data_w-1:0]   read2data;
    logic [isa_pkg::data_w-1:0]   pc;
  } exec_ctrl_t;

  // Execute results, second stage payload
  typedef struct packed {
    logic [isa_pkg::data_w-1:0]   alu_result;
    logic [isa_pkg::data_w-1:0]   branch_target;
    logic [isa_pkg::data_w-1:0]   jump_target;
    logic                         zero;
    logic                         ltz;
    logic                         err;
  } exec_res_t;

endpackage

`default_nettype wire

//--- verilog/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,   // Capture strobe
  input  payload_t d,
  output logic     valid,  // High for one cycle per load
  output payload_t q
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
      q     <= '0;
    end else begin
      valid <= load;
      // Payload holds between loads
      if (load) begin
        q <= d;
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  logic [isa_pkg::data_w-1:0] a,
  input  logic [isa_pkg::data_w-1:0] b,
  input  exec_pkg::alu_op_t          op,
  output logic [isa_pkg::data_w-1:0] y,
  output logic                       ofl,   // Signed overflow of add/sub
  output logic                       zero,
  output logic                       ltz
);

  import isa_pkg::*;
  import exec_pkg::*;

  logic [3:0]          cnt;      // Shift amount, low bits of b
  logic [3:0]          rot_cnt;  // Left-rotate amount
  logic [2*data_w-1:0] rot_dbl;
  logic [data_w-1:0]   rot_y;
  logic [data_w-1:0]   sum, diff;
  logic                sum_ofl, diff_ofl;

  assign cnt = b[3:0];

  // Rotate right by n is rotate left by 16 - n
  assign rot_cnt = (op == alu_ror) ? (4'd0 - cnt) : cnt;
  assign rot_dbl = {a, a} << rot_cnt;           // Upper half holds the rotated word
  assign rot_y   = rot_dbl[2*data_w-1 -: data_w];

  assign sum  = a + b;
  assign diff = a - b;

  // Same-sign inputs giving a different-sign sum
  assign sum_ofl  = (a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
  // Different-sign inputs, result sign flips away from a
  assign diff_ofl = (a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);

  always_comb begin
    ofl = 1'b0;
    case (op)
      alu_add: begin
        y   = sum;
        ofl = sum_ofl;
      end
      alu_sub: begin
        y   = diff;
        ofl = diff_ofl;
      end
      alu_xor:  y = a ^ b;
      alu_andn: y = a & ~b;
      alu_rol:  y = rot_y;
      alu_sll:  y = a << cnt;
      alu_ror:  y = rot_y;
      alu_srl:  y = a >> cnt;
      default:  y = '0;
    endcase
  end

  assign zero = (y == '0);

  // True signed a < b for sub, plain sign bit otherwise
  assign ltz = (op == alu_sub) ? (y[data_w-1] ^ ofl) : y[data_w-1];

endmodule

`default_nettype wire

//--- verilog/exec_decode.sv
`timescale 1ns/1ps
`default_nettype none

module exec_decode (
  input  logic [isa_pkg::data_w-1:0] instr,
  output exec_pkg::alu_op_t          alu_op,
  output exec_pkg::b_sel_t           b_sel,
  output exec_pkg::res_sel_t         res_sel,
  output exec_pkg::set_cond_t        set_cond,
  output exec_pkg::jump_base_t       jump_base,
  output logic [isa_pkg::data_w-1:0] imm,
  output logic                       illegal
);

  import isa_pkg::*;
  import exec_pkg::*;

  logic [op_w-1:0]          opcode;
  logic [fn_msb-fn_lsb:0]   func;
  logic [data_w-1:0]        imm_s5, imm_z5;   // imm5 extended
  logic [data_w-1:0]        imm_s8, imm_z8;   // imm8 extended
  logic [data_w-1:0]        imm_s11;          // disp11 extended

  assign opcode = instr[op_msb:op_lsb];
  assign func   = instr[fn_msb:fn_lsb];

  assign imm_s5  = {{(data_w-imm5_msb-1){instr[imm5_msb]}}, instr[imm5_msb:0]};
  assign imm_z5  = {{(data_w-imm5_msb-1){1'b0}}, instr[imm5_msb:0]};
  assign imm_s8  = {{(data_w-imm8_msb-1){instr[imm8_msb]}}, instr[imm8_msb:0]};
  assign imm_z8  = {{(data_w-imm8_msb-1){1'b0}}, instr[imm8_msb:0]};
  assign imm_s11 = {{(data_w-disp11_msb-1){instr[disp11_msb]}}, instr[disp11_msb:0]};

  always_comb begin
    // Plain add of two registers unless told otherwise
    alu_op    = alu_add;
    b_sel     = b_read2;
    res_sel   = res_alu;
    set_cond  = cond_eq;
    jump_base = jb_pc;
    imm       = '0;
    illegal   = 1'b0;

    case (opcode)
      op_addi: begin
        b_sel = b_imm;
        imm   = imm_s5;
      end
      op_subi: begin
        alu_op = alu_sub;
        b_sel  = b_imm_swap;  // imm - read1data
        imm    = imm_s5;
      end
      op_xori, op_andni: begin
        alu_op = (opcode == op_xori) ? alu_xor : alu_andn;
        b_sel  = b_imm;
        imm    = imm_z5;  // Logic immediates are unsigned
      end
      op_roli, op_slli, op_rori, op_srli: begin
        alu_op = alu_op_t'({1'b1, opcode[1:0]});  // Same order as the ALU enum
        b_sel  = b_imm;
        imm    = imm_z5;
      end
      op_st, op_ld, op_stu: begin
        b_sel = b_imm;  // Address rs + imm
        imm   = imm_s5;
      end
      op_btr:     res_sel = res_btr;
      op_alu_r:   alu_op = alu_op_t'({1'b0, func});
      op_shift_r: alu_op = alu_op_t'({1'b1, func});
      op_seq, op_slt, op_sle, op_sco: begin
        alu_op   = alu_sub;                    // Flags of rs - rt
        res_sel  = res_set_cond;
        set_cond = set_cond_t'(opcode[1:0]);
      end
      op_beqz, op_bnez, op_bltz, op_bgez: begin
        b_sel   = b_imm;
        res_sel = res_pass_b;
        imm     = imm_s8;  // Branch offset
      end
      op_lbi: begin
        b_sel   = b_imm;
        res_sel = res_pass_b;
        imm     = imm_s8;
      end
      op_slbi: begin
        b_sel   = b_imm;
        res_sel = res_slbi;
        imm     = imm_z8;  // OR'd into the low byte
      end
      op_j, op_jal: begin
        b_sel   = b_imm;
        res_sel = res_pass_b;
        imm     = imm_s11;
      end
      op_jr, op_jalr: begin
        b_sel     = b_imm;
        res_sel   = res_pass_b;
        jump_base = jb_read1;  // Register relative
        imm       = imm_s5;
      end
      op_nop: begin
        b_sel   = b_imm;  // Result is the zero immediate
        res_sel = res_pass_b;
      end
      default: begin
        illegal = 1'b1;
        res_sel = res_pass_b;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
  input  exec_pkg::alu_op_t          alu_op,
  input  exec_pkg::b_sel_t           b_sel,
  input  exec_pkg::res_sel_t         res_sel,
  input  exec_pkg::set_cond_t        set_cond,
  input  exec_pkg::jump_base_t       jump_base,
  input  logic [isa_pkg::data_w-1:0] imm,
  input  logic                       illegal,
  input  logic [isa_pkg::data_w-1:0] read1data,
  input  logic [isa_pkg::data_w-1:0] read2data,
  input  logic [isa_pkg::data_w-1:0] pc,
  output logic [isa_pkg::data_w-1:0] alu_result,
  output logic [isa_pkg::data_w-1:0] branch_target,
  output logic [isa_pkg::data_w-1:0] jump_target,
  output logic                       zero,
  output logic                       ltz,
  output logic                       err
);

  import isa_pkg::*;
  import exec_pkg::*;

  logic [data_w-1:0] base_a;     // A before the swap
  logic [data_w-1:0] opa, opb;   // ALU operands
  logic [data_w-1:0] y;
  logic              ofl;
  logic [data_w:0]   co_sum;     // Add with carry out, for sco
  logic              cond_hit;
  logic [data_w-1:0] btr_res;
  logic [data_w-1:0] pc_plus2;
  logic [data_w-1:0] jump_src;

  // slbi works on rt shifted up a byte
  assign base_a = (res_sel == res_slbi) ? (read2data << 8) : read1data;

  always_comb begin
    case (b_sel)
      b_imm: begin
        opa = base_a;
        opb = imm;
      end
      b_imm_swap: begin  // subi computes imm - rs
        opa = imm;
        opb = read1data;
      end
      default: begin
        opa = base_a;
        opb = read2data;
      end
    endcase
  end

  alu i_alu (
    .a    (opa),
    .b    (opb),
    .op   (alu_op),
    .y    (y),
    .ofl  (ofl),
    .zero (zero),
    .ltz  (ltz)
  );

  assign co_sum = {1'b0, opa} + {1'b0, opb};

  // Set ops read the flags of opa - opb
  always_comb begin
    case (set_cond)
      cond_eq: cond_hit = zero;
      cond_lt: cond_hit = ltz;
      cond_le: cond_hit = zero | ltz;
      default: cond_hit = co_sum[data_w];  // Carry out of opa + opb
    endcase
  end

  always_comb begin
    for (int i = 0; i < data_w; i++) begin
      btr_res[i] = read1data[data_w-1-i];  // Bit reverse
    end
  end

  always_comb begin
    case (res_sel)
      res_pass_b:   alu_result = opb;                 // lbi, branches, jumps
      res_set_cond: alu_result = {{(data_w-1){1'b0}}, cond_hit};
      res_btr:      alu_result = btr_res;
      res_slbi:     alu_result = base_a | imm;        // (rt << 8) | imm8
      default:      alu_result = y;
    endcase
  end

  // Target adders
  assign pc_plus2      = pc + data_w'(2);
  assign branch_target = pc_plus2 + imm;
  assign jump_src      = (jump_base == jb_read1) ? read1data : pc_plus2;
  assign jump_target   = jump_src + imm;

  // ALU only flags overflow for add and sub
  assign err = illegal | (ofl & (res_sel == res_alu));

endmodule

`default_nettype wire

//--- verilog/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       valid_in,    // One strobe per instruction
  input  logic [isa_pkg::data_w-1:0] instr,
  input  logic [isa_pkg::data_w-1:0] read1data,
  input  logic [isa_pkg::data_w-1:0] read2data,
  input  logic [isa_pkg::data_w-1:0] pc,
  output logic                       valid_out,   // Two cycles after valid_in
  output logic [isa_pkg::data_w-1:0] alu_result,
  output logic [isa_pkg::data_w-1:0] branch_target,
  output logic [isa_pkg::data_w-1:0] jump_target,
  output logic                       zero,
  output logic                       ltz,
  output logic                       err
);

  import isa_pkg::*;
  import exec_pkg::*;

  // Decoder outputs
  alu_op_t           dec_alu_op;
  b_sel_t            dec_b_sel;
  res_sel_t          dec_res_sel;
  set_cond_t         dec_set_cond;
  jump_base_t        dec_jump_base;
  logic [data_w-1:0] dec_imm;
  logic              dec_illegal;

  exec_ctrl_t        ctrl_d, ctrl_q;
  logic              ctrl_valid;

  // Execute outputs
  logic [data_w-1:0] ex_alu_result, ex_branch_target, ex_jump_target;
  logic              ex_zero, ex_ltz, ex_err;

  exec_res_t         res_d, res_q;

  exec_decode i_decode (
    .instr     (instr),
    .alu_op    (dec_alu_op),
    .b_sel     (dec_b_sel),
    .res_sel   (dec_res_sel),
    .set_cond  (dec_set_cond),
    .jump_base (dec_jump_base),
    .imm       (dec_imm),
    .illegal   (dec_illegal)
  );

  // Operands and pc ride along with the controls
  assign ctrl_d = '{alu_op: dec_alu_op, b_sel: dec_b_sel, res_sel: dec_res_sel,
                    set_cond: dec_set_cond, jump_base: dec_jump_base, imm: dec_imm,
                    illegal: dec_illegal, read1data: read1data, read2data: read2data,
                    pc: pc};

  stage_reg #(.payload_t(exec_ctrl_t)) i_ctrl_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (valid_in),
    .d     (ctrl_d),
    .valid (ctrl_valid),
    .q     (ctrl_q)
  );

  execute i_execute (
    .alu_op        (ctrl_q.alu_op),
    .b_sel         (ctrl_q.b_sel),
    .res_sel       (ctrl_q.res_sel),
    .set_cond      (ctrl_q.set_cond),
    .jump_base     (ctrl_q.jump_base),
    .imm           (ctrl_q.imm),
    .illegal       (ctrl_q.illegal),
    .read1data     (ctrl_q.read1data),
    .read2data     (ctrl_q.read2data),
    .pc            (ctrl_q.pc),
    .alu_result    (ex_alu_result),
    .branch_target (ex_branch_target),
    .jump_target   (ex_jump_target),
    .zero          (ex_zero),
    .ltz           (ex_ltz),
    .err           (ex_err)
  );

  assign res_d = '{alu_result: ex_alu_result, branch_target: ex_branch_target,
                   jump_target: ex_jump_target, zero: ex_zero, ltz: ex_ltz, err: ex_err};

  stage_reg #(.payload_t(exec_res_t)) i_res_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (ctrl_valid),  // Only valid controls produce a result
    .d     (res_d),
    .valid (valid_out),
    .q     (res_q)
  );

  assign alu_result    = res_q.alu_result;
  assign branch_target = res_q.branch_target;
  assign jump_target   = res_q.jump_target;
  assign zero          = res_q.zero;
  assign ltz           = res_q.ltz;
  assign err           = res_q.err;

endmodule

`default_nettype wire

//--- verification/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// Reference model of the execute stage, built from the ISA rules
// kind: 0 add, 1 sub, 2 xor, 3 andn, 4 rol, 5 sll, 6 ror, 7 srl, -1 not an ALU form
function automatic void operands_of(input logic [15:0] ins, input logic [15:0] r1,
                                    input logic [15:0] r2, output logic [15:0] a,
                                    output logic [15:0] b, output int kind);
  logic [4:0] op;
  op   = ins[15:11];
  a    = r1;
  b    = r2;
  kind = -1;
  case (op)
    op_alu_r:   kind = int'(ins[1:0]);
    op_shift_r: kind = 4 + int'(ins[1:0]);
    op_addi, op_st, op_ld, op_stu: begin
      b    = {{11{ins[4]}}, ins[4:0]};  // Signed imm5
      kind = 0;
    end
    op_subi: begin
      a    = {{11{ins[4]}}, ins[4:0]};  // imm - rs
      b    = r1;
      kind = 1;
    end
    op_xori: begin
      b    = {11'h0, ins[4:0]};
      kind = 2;
    end
    op_andni: begin
      b    = {11'h0, ins[4:0]};
      kind = 3;
    end
    op_roli, op_slli, op_rori, op_srli: begin
      b = {11'h0, ins[4:0]};
      case (op)
        op_roli: kind = 4;
        op_slli: kind = 5;
        op_rori: kind = 6;
        default: kind = 7;
      endcase
    end
    default: ;
  endcase
endfunction

function automatic logic [15:0] alu_y(input int kind, input logic [15:0] a, b);
  int m;
  m = int'(b[3:0]);
  case (kind)
    0:       return a + b;
    1:       return a - b;
    2:       return a ^ b;
    3:       return a & ~b;
    4:       return (a << m) | (a >> (16 - m));
    5:       return a << m;
    6:       return (a >> m) | (a << (16 - m));
    default: return a >> m;
  endcase
endfunction

function automatic logic ofl_of(input int kind, input logic [15:0] a, b);
  int s;
  if (kind == 0) s = int'($signed(a)) + int'($signed(b));
  else if (kind == 1) s = int'($signed(a)) - int'($signed(b));
  else return 1'b0;
  return (s > 32767) || (s < -32768);  // Outside the 16-bit signed range
endfunction

function automatic logic [15:0] result_of(input logic [15:0] ins, r1, r2);
  logic [15:0] a, b, rev;
  logic [16:0] wide;
  int          kind;
  operands_of(ins, r1, r2, a, b, kind);
  if (kind >= 0) return alu_y(kind, a, b);
  wide = {1'b0, r1} + {1'b0, r2};
  for (int i = 0; i < 16; i++) rev[i] = r1[15-i];
  case (ins[15:11])
    op_seq:  return {15'h0, r1 == r2};
    op_slt:  return {15'h0, $signed(r1) < $signed(r2)};
    op_sle:  return {15'h0, $signed(r1) <= $signed(r2)};
    op_sco:  return {15'h0, wide[16]};
    op_btr:  return rev;
    op_lbi, op_beqz, op_bnez, op_bltz, op_bgez: return {{8{ins[7]}}, ins[7:0]};
    op_slbi: return {r2[7:0], ins[7:0]};
    op_j, op_jal: return {{5{ins[10]}}, ins[10:0]};
    op_jr, op_jalr: return {{11{ins[4]}}, ins[4:0]};
    op_nop:  return 16'h0;
    default: return r2;  // Illegal passes rt
  endcase
endfunction

// {zero, ltz} for the ALU forms
function automatic logic [1:0] flags_of(input logic [15:0] ins, r1, r2);
  logic [15:0] a, b, y;
  int          kind;
  operands_of(ins, r1, r2, a, b, kind);
  y = alu_y(kind, a, b);
  return {y == 16'h0, (kind == 1) ? ($signed(a) < $signed(b)) : y[15]};
endfunction

function automatic logic err_of(input logic [15:0] ins, r1, r2);
  logic [15:0] a, b;
  int          kind;
  operands_of(ins, r1, r2, a, b, kind);
  if (!(ins[15:11] inside {op_addi, op_subi, op_xori, op_andni, op_roli, op_slli, op_rori,
        op_srli, op_st, op_ld, op_stu, op_btr, op_alu_r, op_shift_r, op_seq, op_slt,
        op_sle, op_sco, op_beqz, op_bnez, op_bltz, op_bgez, op_lbi, op_slbi, op_j,
        op_jal, op_jr, op_jalr, op_nop}))
    return 1'b1;
  return ofl_of(kind, a, b);
endfunction

function automatic logic [15:0] jump_of(input logic [15:0] ins, r1, pc_v);
  if (ins[15:11] == op_jr || ins[15:11] == op_jalr) return r1 + {{11{ins[4]}}, ins[4:0]};
  return pc_v + 16'd2 + {{5{ins[10]}}, ins[10:0]};
endfunction

`endif

//--- verification/tb_exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit;

  import isa_pkg::*;

  `include "exec_model.svh"

  localparam int strobe_count = 305;                  // All strobes over all tests
  localparam int cycle_limit  = 3 * strobe_count + 200;  // Three cycles per single issue

  logic        clk, rst_n, valid_in;
  logic [15:0] instr, read1data, read2data, pc;
  logic        valid_out, zero, ltz, err;
  logic [15:0] alu_result, branch_target, jump_target;

  logic [31:0] lfsr = 32'hf2fe;
  int          cycles = 0;
  int          errors = 0;
  int          checks = 0;
  string       cur_test;

  exec_unit i_dut (
    .clk(clk), .rst_n(rst_n), .valid_in(valid_in), .instr(instr),
    .read1data(read1data), .read2data(read2data), .pc(pc),
    .valid_out(valid_out), .alu_result(alu_result), .branch_target(branch_target),
    .jump_target(jump_target), .zero(zero), .ltz(ltz), .err(err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout, run went past %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // Galois LFSR, one step per bit
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v    = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_word(input string sig, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %s: %s got %h expected %h", cur_test, sig, got, exp);
    end
  endtask

  // Strobe one instruction, result expected at the second falling edge
  task automatic issue(input logic [15:0] ins, r1, r2, pc_v);
    @(posedge clk);
    valid_in  <= 1'b1;
    instr     <= ins;
    read1data <= r1;
    read2data <= r2;
    pc        <= pc_v;
    @(negedge clk);
    if (valid_out) begin
      errors++;
      $display("%s: valid_out high without a strobe", cur_test);
    end
    @(posedge clk);
    valid_in <= 1'b0;
    @(negedge clk);
    if (valid_out) begin
      errors++;
      $display("%s: valid_out came one cycle early", cur_test);
    end
    @(negedge clk);
    if (!valid_out) begin
      errors++;
      $display("%s: valid_out missing two cycles after the strobe", cur_test);
    end
  endtask

  task automatic report(input int err_before, input int chk_before);
    $display("%s: %0d checks, %0d errors", cur_test, checks - chk_before,
             errors - err_before);
  endtask

  task automatic run_checked(input logic [15:0] ins, r1, r2, pc_v, input logic do_flags);
    logic [1:0] fl;
    issue(ins, r1, r2, pc_v);
    fl = flags_of(ins, r1, r2);
    check_word("alu_result", alu_result, result_of(ins, r1, r2));
    check_word("err", {15'h0, err}, {15'h0, err_of(ins, r1, r2)});
    if (do_flags) begin
      check_word("zero", {15'h0, zero}, {15'h0, fl[1]});
      check_word("ltz", {15'h0, ltz}, {15'h0, fl[0]});
    end
  endtask

  task automatic test_reset;
    int e0, c0;
    e0 = errors;
    c0 = checks;
    cur_test = "reset";
    for (int k = 0; k < 7; k++) begin
      @(posedge clk);
      if (k == 4) rst_n <= 1'b1;  // Released after 4 cycles
      @(negedge clk);
      check_word("valid_out", {15'h0, valid_out}, 16'h0);
      check_word("alu_result", alu_result, 16'h0);
      check_word("branch_target", branch_target, 16'h0);
      check_word("jump_target", jump_target, 16'h0);
      check_word("flags", {13'h0, zero, ltz, err}, 16'h0);
    end
    report(e0, c0);
  endtask

  task automatic test_arith;
    logic [4:0] ops [4] = '{op_addi, op_subi, op_xori, op_andni};
    int e0, c0;
    e0 = errors;
    c0 = checks;
    cur_test = "arith";
    for (int i = 0; i < 12; i++) begin
      for (int f = 0; f < 4; f++) begin
        run_checked({op_alu_r, 9'h0, 2'(f)}, rand_bits(16), rand_bits(16), 16'h0, 1'b1);
        run_checked({ops[f], 6'h0, 5'(rand_bits(5))}, rand_bits(16), 16'h0, 16'h0, 1'b1);
      end
    end
    report(e0, c0);
  endtask

  task automatic test_shift;
    logic [4:0] ops [4] = '{op_roli, op_slli, op_rori, op_srli};
    int e0, c0;
    e0 = errors;
    c0 = checks;
    cur_test = "shift";
    for (int n = 0; n < 16; n++) begin
      for (int f = 0; f < 4; f++) begin
        run_checked({op_shift_r, 9'h0, 2'(f)}, rand_bits(16), {12'(rand_bits(12)), 4'(n)},
                    16'h0, 1'b1);
        run_checked({ops[f], 6'h0, 1'(rand_bits(1)), 4'(n)}, rand_bits(16), 16'h0,
                    16'h0, 1'b1);
      end
    end
    report(e0, c0);
  endtask

  task automatic test_set_misc;
    logic [4:0]  ops [4] = '{op_seq, op_slt, op_sle, op_sco};
    logic [15:0] av [6]  = '{16'd5, 16'd3, 16'd9, 16'hfffc, 16'hf000, 16'h8000};
    logic [15:0] bv [6]  = '{16'd5, 16'd9, 16'd3, 16'h0002, 16'h2000, 16'h0001};
    int e0, c0;
    e0 = errors;
    c0 = checks;
    cur_test = "set_misc";
    for (int f = 0; f < 4; f++) begin
      for (int p = 0; p < 6; p++) run_checked({ops[f], 11'h0}, av[p], bv[p], 16'h0, 1'b0);
    end
    for (int i = 0; i < 4; i++) run_checked({op_btr, 11'h0}, rand_bits(16), 16'h0, 16'h0, 1'b0);
    run_checked({op_lbi, 3'h0, 8'h85}, 16'h0, 16'h0, 16'h0, 1'b0);
    run_checked({op_lbi, 3'h0, 8'h7a}, 16'h0, 16'h0, 16'h0, 1'b0);
    run_checked({op_slbi, 3'h0, 8'h9c}, 16'h0, 16'h12d4, 16'h0, 1'b0);
    run_checked({op_slbi, 3'h0, 8'h01}, 16'h0, rand_bits(16), 16'h0, 1'b0);
    run_checked({op_ld, 6'h0, 5'h13}, 16'h4000, 16'h0, 16'h0, 1'b0);
    run_checked({op_st, 6'h0, 5'h07}, rand_bits(16), 16'h0, 16'h0, 1'b0);
    run_checked({op_stu, 6'h0, 5'h1f}, rand_bits(16), 16'h0, 16'h0, 1'b0);
    report(e0, c0);
  endtask

  task automatic test_targets;
    logic [4:0]  ops [8] = '{op_beqz, op_bnez, op_bltz, op_bgez, op_j, op_jal, op_jr, op_jalr};
    logic [15:0] ins, r1, pc_v;
    int e0, c0;
    e0 = errors;
    c0 = checks;
    cur_test = "targets";
    for (int f = 0; f < 8; f++) begin
      for (int i = 0; i < 4; i++) begin
        ins     = {ops[f], 11'(rand_bits(11))};
        ins[10] = i[0];  // Alternate sign of disp11
        ins[7]  = i[0];
        ins[4]  = i[1];
        r1      = rand_bits(16);
        pc_v    = {15'(rand_bits(15)), 1'b0};
        issue(ins, r1, 16'h0, pc_v);
        if (f < 4) check_word("branch_target", branch_target,
                              pc_v + 16'd2 + {{8{ins[7]}}, ins[7:0]});
        else check_word("jump_target", jump_target, jump_of(ins, r1, pc_v));
      end
    end
    report(e0, c0);
  endtask

  task automatic test_errors;
    int e0, c0;
    e0 = errors;
    c0 = checks;
    cur_test = "errors";
    run_checked({op_alu_r, 11'h0}, 16'h7fff, 16'h0001, 16'h0, 1'b0);  // add overflow
    run_checked({op_alu_r, 11'h1}, 16'h8000, 16'h0001, 16'h0, 1'b0);  // sub overflow
    run_checked({op_addi, 6'h0, 5'h01}, 16'h7fff, 16'h0, 16'h0, 1'b0);
    run_checked({op_subi, 6'h0, 5'h01}, 16'h8000, 16'h0, 16'h0, 1'b0);
    run_checked({op_alu_r, 11'h2}, 16'h7fff, 16'h8001, 16'h0, 1'b0);
    run_checked({op_lbi, 3'h0, 8'h7f}, 16'h7fff, 16'h0, 16'h0, 1'b0);  // Underlying add overflows
    run_checked({op_seq, 11'h0}, 16'h7fff, 16'hffff, 16'h0, 1'b0);
    run_checked({op_btr, 11'h0}, 16'h8000, 16'h8000, 16'h0, 1'b0);  // Underlying add overflows
    run_checked({op_slbi, 3'h0, 8'hff}, 16'h0, 16'h7fff, 16'h0, 1'b0);
    run_checked({5'b00000, 11'h0}, 16'h1234, 16'h5678, 16'h0, 1'b0);  // Undefined opcodes
    run_checked({5'b00011, 11'h0}, 16'h1234, 16'h5678, 16'h0, 1'b0);
    report(e0, c0);
  endtask

  task automatic test_timing;
    logic [15:0] r1v [3] = '{16'd10, 16'd20, 16'd30};
    int e0, c0;
    e0 = errors;
    c0 = checks;
    cur_test = "timing";
    for (int k = 0; k < 6; k++) begin
      @(posedge clk);
      if (k < 3) begin
        valid_in  <= 1'b1;
        instr     <= {op_addi, 6'h0, 5'h03};
        read1data <= r1v[k];
      end else begin
        valid_in <= 1'b0;
      end
      @(negedge clk);
      check_word("valid_out", {15'h0, valid_out}, {15'h0, k >= 2 && k <= 4});
      if (k >= 2 && k <= 4) check_word("alu_result", alu_result, r1v[k-2] + 16'd3);
    end
    report(e0, c0);
  endtask

  initial begin
    rst_n     = 1'b0;
    valid_in  = 1'b0;
    instr     = '0;
    read1data = '0;
    read2data = '0;
    pc        = '0;
    test_reset();
    test_arith();
    test_shift();
    test_set_misc();
    test_targets();
    test_errors();
    test_timing();
    $display("Total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+verification
verilog/isa_pkg.sv
verilog/exec_pkg.sv
verilog/stage_reg.sv
verilog/alu.sv
verilog/exec_decode.sv
verilog/execute.sv
verilog/exec_unit.sv
verification/tb_exec_unit.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f all.f --top-module tb_exec_unit
	./obj_dir/Vtb_exec_unit | tee /dev/stderr | grep -q '^\*\*\* PASSED \*\*\*$$'

clean:
	rm -rf obj_dir
